//--- hdl/upPkg.sv
`default_nettype none

package upPkg;

	// opcode byte of each two-byte instruction.
	typedef enum logic [7:0] {
		opLdi = 8'h01,  // acc = operand byte.
		opLda = 8'h02,  // acc = mem[operand].
		opSta = 8'h03,  // mem[operand] = acc.
		opAdd = 8'h04,
		opSub = 8'h05,
		opAnd = 8'h06,
		opOr  = 8'h07,
		opXor = 8'h08,
		opJmp = 8'h09,
		opJz  = 8'h0A,  // taken when the zero flag is set.
		opHlt = 8'h0F
	} opcode_t;

	// controller FSM states, one instruction takes the last three.
	typedef enum logic [1:0] {
		stIdle     = 2'd0,
		stFetchOp  = 2'd1,
		stFetchArg = 2'd2,
		stExec     = 2'd3
	} cpuState_t;

	// controller request into the memory.
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wrData;
		logic       we;
	} memReq_t;

	// one byte write on the host port.
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} hostWrite_t;

	// boot program: ldi 0x21, add [0x80], sta 0x7F, hlt.
	// leaves 0x21 + 0xB6 = 0xD7 in the result byte.
	parameter logic [7:0] bootImage [256] = '{
		0:       8'h01,
		1:       8'h21,
		2:       8'h04,
		3:       8'h80,
		4:       8'h03,
		5:       8'h7F,
		6:       8'h0F,
		7:       8'h00,
		8'h80:   8'hB6,
		default: 8'h00
	};

endpackage

`default_nettype wire

//--- hdl/upAlu.sv
`timescale 1ns/1ps
`default_nettype none

module upAlu import upPkg::*; (
	input  opcode_t    op,
	input  logic [7:0] acc,
	input  logic [7:0] operand,
	output logic [7:0] accNext,
	output logic       zero
);

	// acc is always the left operand.
	always_comb begin
		case (op)
			opLdi,
			opLda: begin
				accNext = operand;
			end
			opAdd: begin
				accNext = acc + operand;  // wraps mod 256.
			end
			opSub: begin
				accNext = acc - operand;
			end
			opAnd: begin
				accNext = acc & operand;
			end
			opOr: begin
				accNext = acc | operand;
			end
			opXor: begin
				accNext = acc ^ operand;
			end
			default: begin
				accNext = acc;  // no change for non-alu opcodes.
			end
		endcase
	end

	assign zero = (accNext == 8'h00);

endmodule

`default_nettype wire

//--- hdl/upMemory.sv
`timescale 1ns/1ps
`default_nettype none

module upMemory import upPkg::*; #(
	parameter int ReadyDelay = 5
) (
	input  logic       clk,
	input  logic       nRst,
	input  memReq_t    req,
	output logic [7:0] rdData,
	output logic       memReady,
	output logic [7:0] result
);

	localparam int CntW = $clog2(ReadyDelay + 1);
	localparam logic [CntW-1:0] CntMax = CntW'(ReadyDelay);
	localparam logic [7:0] ResultAddr = 8'h7F;

	logic [7:0]      mem [256];
	logic [CntW-1:0] readyCnt;
	logic            cntDone;

	// asynchronous read port.
	assign rdData = mem[req.addr];

	// the result byte is just a tap on the array.
	assign result = mem[ResultAddr];

	assign cntDone = (readyCnt == CntMax);
	assign memReady = cntDone;

	// counts edges after reset and holds at the limit.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			readyCnt <= '0;
		end else if (!cntDone) begin
			readyCnt <= readyCnt + 1'b1;
		end
	end

	// reset reloads the whole boot image, so a rerun after
	// reset always sees the same program and data.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= bootImage[i];
			end
		end else if (req.we) begin
			mem[req.addr] <= req.wrData;  // single write port.
		end
	end

endmodule

`default_nettype wire

//--- hdl/upControl.sv
`timescale 1ns/1ps
`default_nettype none

module upControl import upPkg::*; (
	input  logic       clk,
	input  logic       nRst,
	input  logic       memReady,
	input  logic       start,
	input  logic       hostValid,
	input  hostWrite_t hostWr,
	output logic       hostReady,
	input  logic [7:0] rdData,
	output memReq_t    req,
	output opcode_t    aluOp,
	output logic [7:0] aluOperand,
	input  logic [7:0] accNext,
	input  logic       aluZero,
	output logic       busy,
	output logic       halted,
	output logic       illegal
);

	cpuState_t  state;
	opcode_t    opReg;
	logic [7:0] argReg;
	logic [7:0] pc;
	logic [7:0] acc;
	logic       zeroFlag;
	logic       hostXfer;
	logic       startOk;
	logic       writesAcc;
	logic       isIllegal;

	// host port and start are only served in idle once the memory is ready.
	assign hostReady = (state == stIdle) && memReady;
	assign hostXfer = hostValid && hostReady;
	assign startOk = start && hostReady && !hostValid;  // a host write wins.

	assign busy = (state != stIdle);

	assign aluOp = opReg;
	assign aluOperand = (opReg == opLdi) ? argReg : rdData;

	// decode of the latched opcode.
	always_comb begin
		writesAcc = 1'b0;
		isIllegal = 1'b0;
		case (opReg)
			opLdi, opLda, opAdd, opSub, opAnd, opOr, opXor: begin
				writesAcc = 1'b1;
			end
			opSta, opJmp, opJz, opHlt: begin
				writesAcc = 1'b0;
			end
			default: begin
				isIllegal = 1'b1;
			end
		endcase
	end

	// memory port mux.
	always_comb begin
		req = '0;
		case (state)
			stIdle: begin
				req.addr = hostWr.addr;
				req.wrData = hostWr.data;
				req.we = hostXfer;
			end
			stFetchOp, stFetchArg: begin
				req.addr = pc;
			end
			stExec: begin
				req.addr = argReg;  // data address for lda, alu ops and sta.
				req.wrData = acc;
				req.we = (opReg == opSta);
			end
			default: begin
				req = '0;
			end
		endcase
	end

	// instruction bytes, only meaningful after they are fetched.
	always_ff @(posedge clk) begin
		if (state == stFetchOp) begin
			opReg <= opcode_t'(rdData);
		end
		if (state == stFetchArg) begin
			argReg <= rdData;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stIdle;
			pc <= '0;
			acc <= '0;
			zeroFlag <= 1'b0;
			halted <= 1'b0;
			illegal <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (startOk) begin
						pc <= '0;
						halted <= 1'b0;
						illegal <= 1'b0;
						state <= stFetchOp;
					end
				end
				stFetchOp: begin
					pc <= pc + 8'd1;
					state <= stFetchArg;
				end
				stFetchArg: begin
					pc <= pc + 8'd1;
					state <= stExec;
				end
				stExec: begin
					state <= stFetchOp;
					if (writesAcc) begin
						acc <= accNext;
						zeroFlag <= aluZero;
					end
					if (opReg == opJmp) begin
						pc <= argReg;
					end
					if ((opReg == opJz) && zeroFlag) begin
						pc <= argReg;
					end
					// halt and illegal both stop the run.
					if ((opReg == opHlt) || isIllegal) begin
						halted <= 1'b1;
						illegal <= isIllegal;
						state <= stIdle;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/upCpu.sv
`timescale 1ns/1ps
`default_nettype none

module upCpu import upPkg::*; #(
	parameter int ReadyDelay = 5
) (
	input  logic       clk,
	input  logic       nRst,
	input  logic       start,
	input  logic       hostValid,
	input  hostWrite_t hostWr,
	output logic       hostReady,
	output logic       busy,
	output logic       halted,
	output logic       illegal,
	output logic [7:0] result
);

	memReq_t    req;
	logic [7:0] rdData;
	logic       memReady;
	opcode_t    aluOp;
	logic [7:0] aluOperand;
	logic [7:0] accNext;
	logic       aluZero;

	upMemory #(
		.ReadyDelay(ReadyDelay)
	) uMemory (
		.clk(clk),
		.nRst(nRst),
		.req(req),
		.rdData(rdData),
		.memReady(memReady),
		.result(result)
	);

	upControl uControl (
		.clk(clk),
		.nRst(nRst),
		.memReady(memReady),
		.start(start),
		.hostValid(hostValid),
		.hostWr(hostWr),
		.hostReady(hostReady),
		.rdData(rdData),
		.req(req),
		.aluOp(aluOp),
		.aluOperand(aluOperand),
		.accNext(accNext),
		.aluZero(aluZero),
		.busy(busy),
		.halted(halted),
		.illegal(illegal)
	);

	// acc comes back out of the controller through accNext only.
	upAlu uAlu (
		.op(aluOp),
		.acc(uControl.acc),
		.operand(aluOperand),
		.accNext(accNext),
		.zero(aluZero)
	);

endmodule

`default_nettype wire

//--- sim/upCpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module upCpuChk import upPkg::*; (
	input logic      clk,
	input logic      nRst,
	input cpuState_t state,
	input logic      hostReady,
	input logic      busy,
	input logic      halted
);

	logic nRstQ;  // low during the first cycle out of reset.

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			nRstQ <= 1'b0;
		end else begin
			nRstQ <= 1'b1;
		end
	end

	readyOnlyIdle: assert property (@(posedge clk) disable iff (!nRst)
		hostReady |-> (state == stIdle))
		else $error("hostReady outside idle");

	haltedNotBusy: assert property (@(posedge clk) disable iff (!nRst)
		!(halted && busy))
		else $error("halted and busy together");

	// halted comes out of reset low.
	haltedAfterReset: assert property (@(posedge clk) disable iff (!nRst)
		!nRstQ |-> !halted)
		else $error("halted set right after reset");

endmodule

bind upControl upCpuChk uChk (
	.clk(clk),
	.nRst(nRst),
	.state(state),
	.hostReady(hostReady),
	.busy(busy),
	.halted(halted)
);

`default_nettype wire

//--- sim/upCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module upCpuTb import upPkg::*; ;

	localparam int ReadyDelay = 5;
	localparam int InstrBudget = 150;  // all runs, long loops included.
	localparam int WriteBudget = 160;
	localparam int WatchdogCycles = InstrBudget * 3 + WriteBudget * 3 + 2 * 20 + 300;

	logic       clk;
	logic       nRst;
	logic       start;
	logic       hostValid;
	hostWrite_t hostWr;
	logic       hostReady;
	logic       busy;
	logic       halted;
	logic       illegal;
	logic [7:0] result;

	logic [15:0] lfsr;
	logic [7:0]  model [256];  // mirror of the DUT memory.
	logic [7:0]  modelAcc;
	logic        modelZero;
	int          checks = 0;
	int          errors = 0;

	upCpu #(
		.ReadyDelay(ReadyDelay)
	) DUT (
		.clk(clk),
		.nRst(nRst),
		.start(start),
		.hostValid(hostValid),
		.hostWr(hostWr),
		.hostReady(hostReady),
		.busy(busy),
		.halted(halted),
		.illegal(illegal),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WatchdogCycles * 10);
		$display("watchdog expired after %0d cycles", WatchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
	function automatic logic [7:0] randByte(input int nBits);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < nBits; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic checkVal(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic applyReset();
		nRst <= 1'b0;
		repeat (5) @(posedge clk);
		nRst <= 1'b1;
		for (int i = 0; i < 256; i++) begin
			model[i] = bootImage[i];
		end
		modelAcc = 8'h00;
		modelZero = 1'b0;
	endtask

	task automatic waitReady(output int lowCycles);
		lowCycles = 0;
		@(negedge clk);
		while (!hostReady && lowCycles < 50) begin
			lowCycles++;
			@(negedge clk);
		end
		if (!hostReady) begin
			errors++;
			$display("memory never became ready after reset");
		end
	endtask

	task automatic hostWrite(input logic [7:0] a, input logic [7:0] d, output int waited);
		@(posedge clk);
		hostValid <= 1'b1;
		hostWr <= '{addr: a, data: d};
		waited = 0;
		do begin
			@(negedge clk);
			if (busy && hostReady) begin
				errors++;
				$display("host port ready while the core is busy");
			end
			if (!hostReady) begin
				waited++;
			end
		end while (!hostReady && waited < 400);
		if (!hostReady) begin
			errors++;
			$display("host write to %h was never accepted", a);
		end else begin
			model[a] = d;
		end
		@(posedge clk);  // transfer edge.
		hostValid <= 1'b0;
	endtask

	task automatic writeByte(input logic [7:0] a, input logic [7:0] d);
		int w;
		hostWrite(a, d, w);
	endtask

	task automatic loadProgram(input logic [7:0] prog [$]);
		foreach (prog[i]) begin
			writeByte(8'(i), prog[i]);
		end
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic runProgram(input int bound);
		int cycles;
		pulseStart();
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			checkVal("busy", 8'(busy), 8'(!halted));  // busy for the whole run.
		end while (!halted && cycles < bound);
		if (!halted) begin
			errors++;
			$display("program did not halt within %0d cycles", bound);
		end
	endtask

	// runs the model memory from address 0 until halt or an illegal opcode.
	task automatic interpret(output int steps, output logic expIllegal);
		logic [7:0] pc;
		logic [7:0] arg;
		opcode_t    op;
		logic       done;
		pc = 8'h00;
		done = 1'b0;
		expIllegal = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			op = opcode_t'(model[pc]);
			arg = model[pc + 8'd1];
			pc = pc + 8'd2;
			steps++;
			case (op)
				opLdi: modelAcc = arg;
				opLda: modelAcc = model[arg];
				opAdd: modelAcc = modelAcc + model[arg];
				opSub: modelAcc = modelAcc - model[arg];
				opAnd: modelAcc = modelAcc & model[arg];
				opOr:  modelAcc = modelAcc | model[arg];
				opXor: modelAcc = modelAcc ^ model[arg];
				opSta: model[arg] = modelAcc;
				opJmp: pc = arg;
				opJz:  pc = modelZero ? arg : pc;
				opHlt: done = 1'b1;
				default: begin
					done = 1'b1;
					expIllegal = 1'b1;
				end
			endcase
			if (op inside {opLdi, opLda, opAdd, opSub, opAnd, opOr, opXor}) begin
				modelZero = (modelAcc == 8'h00);
			end
		end
	endtask

	task automatic checkRun(input string tag);
		int   steps;
		logic expIllegal;
		interpret(steps, expIllegal);
		runProgram(steps * 3 + 4);
		checkVal({tag, " halted"}, 8'(halted), 8'h01);
		checkVal({tag, " illegal"}, 8'(illegal), 8'(expIllegal));
		checkVal({tag, " result"}, result, model[8'h7F]);
	endtask

	// counts up to n at 0x7F, leaving the loop when acc - n is zero.
	task automatic loadLoop(input logic [7:0] n);
		loadProgram('{opLdi, 8'h00, opAdd, 8'h91, opSta, 8'h7F, opSub, 8'h92,
			opJz, 8'h0E, opAdd, 8'h92, opJmp, 8'h02, opHlt, 8'h00});
		writeByte(8'h91, 8'h01);
		writeByte(8'h92, n);
	endtask

	task automatic testBoot();
		int lowCycles;
		applyReset();
		waitReady(lowCycles);
		checkVal("ready delay", 8'(lowCycles), 8'(ReadyDelay));
		checkRun("boot");
		checkVal("boot constant", result, 8'hD7);
	endtask

	task automatic testAluOps();
		opcode_t    ops [6];
		logic [7:0] x;
		logic [7:0] y;
		ops = '{opAdd, opSub, opAnd, opOr, opXor, opLda};
		foreach (ops[i]) begin
			x = randByte(8);
			y = randByte(8);
			loadProgram('{opLdi, x, ops[i], 8'h90, opSta, 8'h7F, opHlt, 8'h00});
			writeByte(8'h90, y);
			checkRun(ops[i].name());
		end
	endtask

	task automatic testBranches();
		logic [7:0] n;
		logic [7:0] x;
		n = randByte(3) + 8'd1;
		loadLoop(n);
		checkRun("loop");
		checkVal("loop count", result, n);
		x = randByte(7) | 8'h80;  // never equal to the old count.
		loadProgram('{opLdi, x, opJz, 8'h08, opSta, 8'h7F, opHlt, 8'h00, opHlt, 8'h00});
		checkRun("jz not taken");
	endtask

	task automatic testBackPressure();
		int         steps;
		int         waited;
		logic       expIllegal;
		logic [7:0] d;
		loadLoop(8'd8);
		interpret(steps, expIllegal);
		d = randByte(8);
		pulseStart();
		hostWrite(8'h7F, d, waited);
		if (waited + 1 < steps * 3) begin
			errors++;
			$display("host write was not held off for the whole run");
		end
		@(negedge clk);
		checkVal("backpressure halted", 8'(halted), 8'h01);
		checkVal("backpressure result", result, d);
	endtask

	task automatic testIllegal();
		logic [7:0] x;
		x = model[8'h7F] ^ 8'h5A;
		loadProgram('{opLdi, x, 8'h3C, 8'h00, opSta, 8'h7F, opHlt, 8'h00});
		checkRun("illegal");
	endtask

	task automatic testReset();
		int lowCycles;
		loadLoop(8'd8);
		pulseStart();
		repeat (20) @(posedge clk);
		applyReset();
		waitReady(lowCycles);
		checkVal("ready delay after reset", 8'(lowCycles), 8'(ReadyDelay));
		checkVal("result after reset", result, 8'h00);
		checkRun("rerun");
		checkVal("rerun constant", result, 8'hD7);
	endtask

	initial begin
		nRst <= 1'b0;
		start <= 1'b0;
		hostValid <= 1'b0;
		hostWr <= '0;
		lfsr = 16'd24514;
		testBoot();
		testAluOps();
		testBranches();
		testBackPressure();
		testIllegal();
		testReset();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- upCpu.f
hdl/upPkg.sv
hdl/upAlu.sv
hdl/upMemory.sv
hdl/upControl.sv
hdl/upCpu.sv
sim/upCpu_chk.sv
sim/upCpuTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module upCpuTb -f upCpu.f
	./obj_dir/VupCpuTb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
